// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_pc_io_fabric
FILELIST  = verilog.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "^TEST OK$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bus_return.sv
`timescale 1ns/1ps
`default_nettype none

module bus_return (
	input  logic                              clk_sys,
	input  logic                              reset_cpu,
	input  pc_io_pkg::io_device_t             io_device,
	input  logic                              io_addr_alt,
	input  logic                              io_read,
	input  logic                              io_write,
	input  logic [pc_io_pkg::IO_SIZE_W-1:0]   io_datasize,
	input  logic [pc_io_pkg::IO_DATA_W-1:0]   io_writedata,
	input  logic [pc_io_pkg::IO_DATA_W-1:0]   hdd0_readdata,
	input  logic [pc_io_pkg::IO_DATA_W-1:0]   hdd1_readdata,
	input  logic [7:0]                        floppy_readdata,
	input  logic [7:0]                        dma_readdata,
	input  logic [7:0]                        pic_readdata,
	input  logic [7:0]                        pit_readdata,
	input  logic [7:0]                        ps2_readdata,
	input  logic [7:0]                        rtc_readdata,
	input  logic [7:0]                        sound_readdata,
	input  logic [7:0]                        uart_readdata,
	input  logic [7:0]                        vga_readdata,
	input  logic [7:0]                        joy_readdata,
	input  pc_io_pkg::mgmt_target_t           mgmt_target,
	input  logic                              mgmt_write,
	input  logic [pc_io_pkg::MGMT_DATA_W-1:0] fdd0_mgmt_readdata,
	input  logic [pc_io_pkg::MGMT_DATA_W-1:0] hdd0_mgmt_readdata,
	input  logic [pc_io_pkg::MGMT_DATA_W-1:0] hdd1_mgmt_readdata,
	output logic [pc_io_pkg::NUM_IO_DEV-1:0]  io_dev_read,
	output logic [pc_io_pkg::NUM_IO_DEV-1:0]  io_dev_write,
	output logic [pc_io_pkg::IO_DATA_W-1:0]   io_readdata,
	output logic                              io_io32,
	output logic [7:0]                        syscfg,
	output logic [4:0]                        mgmt_dev_write,
	output logic [pc_io_pkg::MGMT_DATA_W-1:0] mgmt_readdata
);

	logic [7:0] readdata8;
	logic       is_disk;
	logic       sysctl_load;

	// One-hot strobes, bit DEV_NONE stays low
	always_comb begin
		io_dev_read  = '0;
		io_dev_write = '0;
		if (io_device != pc_io_pkg::DEV_NONE) begin
			io_dev_read[io_device]  = io_read;
			io_dev_write[io_device] = io_write;
		end
	end

	assign is_disk = (io_device == pc_io_pkg::DEV_HDD0) || (io_device == pc_io_pkg::DEV_HDD1);
	assign io_io32 = (is_disk && !io_addr_alt) || (io_device == pc_io_pkg::DEV_SYSCTL);

	always_comb begin
		case (io_device)
			pc_io_pkg::DEV_FDD0:  readdata8 = floppy_readdata;
			pc_io_pkg::DEV_DMA:   readdata8 = dma_readdata;
			pc_io_pkg::DEV_PIC:   readdata8 = pic_readdata;
			pc_io_pkg::DEV_PIT:   readdata8 = pit_readdata;
			pc_io_pkg::DEV_PS2:   readdata8 = ps2_readdata;
			pc_io_pkg::DEV_RTC:   readdata8 = rtc_readdata;
			pc_io_pkg::DEV_SOUND: readdata8 = sound_readdata;
			pc_io_pkg::DEV_UART:  readdata8 = uart_readdata;
			pc_io_pkg::DEV_VGA:   readdata8 = vga_readdata;
			pc_io_pkg::DEV_JOY:   readdata8 = joy_readdata;
			default:              readdata8 = 8'hFF; // Open bus
		endcase
	end

	always_comb begin
		case (io_device)
			pc_io_pkg::DEV_HDD0: io_readdata = hdd0_readdata;
			pc_io_pkg::DEV_HDD1: io_readdata = hdd1_readdata;
			default:             io_readdata = {24'd0, readdata8};
		endcase
	end

	// Keyed word write to the control port
	assign sysctl_load = io_write && (io_device == pc_io_pkg::DEV_SYSCTL) &&
		(io_datasize == pc_io_pkg::SYSCTL_SIZE) &&
		(io_writedata[15:8] == pc_io_pkg::SYSCTL_KEY);

	always_ff @(posedge clk_sys) begin
		if (reset_cpu) begin
			syscfg <= 8'd0;
		end else if (sysctl_load) begin
			syscfg <= io_writedata[7:0];
		end
	end

	always_comb begin
		mgmt_dev_write = '0;
		if (mgmt_target != pc_io_pkg::MGMT_NONE) begin
			mgmt_dev_write[mgmt_target] = mgmt_write;
		end
	end

	always_comb begin
		case (mgmt_target)
			pc_io_pkg::MGMT_HDD0: mgmt_readdata = hdd0_mgmt_readdata;
			pc_io_pkg::MGMT_HDD1: mgmt_readdata = hdd1_mgmt_readdata;
			default:              mgmt_readdata = fdd0_mgmt_readdata; // RTC has no read path
		endcase
	end

endmodule

`default_nettype wire

// File: io_port_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module io_port_decoder (
	input  logic                             clk_sys,
	input  logic                             reset_cpu,
	input  logic [pc_io_pkg::IO_ADDR_W-1:0]  io_address,
	output pc_io_pkg::io_device_t            io_device,
	output logic                             io_addr_alt
);

	pc_io_pkg::io_device_t next_device;

	// Address falls in the block starting at base when the upper bits agree
	function automatic logic in_range(
		input logic [pc_io_pkg::IO_ADDR_W-1:0] addr,
		input logic [pc_io_pkg::IO_ADDR_W-1:0] base,
		input int                              ign
	);
		return (addr >> ign) == (base >> ign);
	endfunction

	// Disks first so 3F6h beats the floppy block and 61h goes to the PIT
	always_comb begin
		if (in_range(io_address, pc_io_pkg::HDD0_BASE, pc_io_pkg::HDD0_IGN) ||
			io_address == pc_io_pkg::HDD0_ALT) begin
			next_device = pc_io_pkg::DEV_HDD0;
		end else if (in_range(io_address, pc_io_pkg::HDD1_BASE, pc_io_pkg::HDD1_IGN) ||
			io_address == pc_io_pkg::HDD1_ALT) begin
			next_device = pc_io_pkg::DEV_HDD1;
		end else if (in_range(io_address, pc_io_pkg::FDD0_BASE, pc_io_pkg::FDD0_IGN)) begin
			next_device = pc_io_pkg::DEV_FDD0;
		end else if (in_range(io_address, pc_io_pkg::DMA_MASTER_BASE,
			pc_io_pkg::DMA_MASTER_IGN) ||
			in_range(io_address, pc_io_pkg::DMA_SLAVE_BASE, pc_io_pkg::DMA_SLAVE_IGN) ||
			in_range(io_address, pc_io_pkg::DMA_PAGE_BASE, pc_io_pkg::DMA_PAGE_IGN)) begin
			next_device = pc_io_pkg::DEV_DMA;
		end else if (in_range(io_address, pc_io_pkg::PIC_MASTER_BASE,
			pc_io_pkg::PIC_MASTER_IGN) ||
			in_range(io_address, pc_io_pkg::PIC_SLAVE_BASE, pc_io_pkg::PIC_SLAVE_IGN)) begin
			next_device = pc_io_pkg::DEV_PIC;
		end else if (in_range(io_address, pc_io_pkg::PIT_BASE, pc_io_pkg::PIT_IGN) ||
			io_address == pc_io_pkg::PIT_ALT) begin
			next_device = pc_io_pkg::DEV_PIT;
		end else if (in_range(io_address, pc_io_pkg::PS2_IO_BASE, pc_io_pkg::PS2_IO_IGN) ||
			in_range(io_address, pc_io_pkg::PS2_CTL_BASE, pc_io_pkg::PS2_CTL_IGN)) begin
			next_device = pc_io_pkg::DEV_PS2;
		end else if (in_range(io_address, pc_io_pkg::RTC_BASE, pc_io_pkg::RTC_IGN)) begin
			next_device = pc_io_pkg::DEV_RTC;
		end else if (in_range(io_address, pc_io_pkg::SB_BASE, pc_io_pkg::SB_IGN) ||
			in_range(io_address, pc_io_pkg::FM_BASE, pc_io_pkg::FM_IGN)) begin
			next_device = pc_io_pkg::DEV_SOUND;
		end else if (in_range(io_address, pc_io_pkg::UART_BASE, pc_io_pkg::UART_IGN) ||
			in_range(io_address, pc_io_pkg::MPU_BASE, pc_io_pkg::MPU_IGN)) begin
			next_device = pc_io_pkg::DEV_UART;
		end else if (in_range(io_address, pc_io_pkg::VGA_B_BASE, pc_io_pkg::VGA_IGN) ||
			in_range(io_address, pc_io_pkg::VGA_C_BASE, pc_io_pkg::VGA_IGN) ||
			in_range(io_address, pc_io_pkg::VGA_D_BASE, pc_io_pkg::VGA_IGN)) begin
			next_device = pc_io_pkg::DEV_VGA;
		end else if (io_address == pc_io_pkg::JOY_PORT) begin
			next_device = pc_io_pkg::DEV_JOY;
		end else if (io_address == pc_io_pkg::SYSCTL_PORT) begin
			next_device = pc_io_pkg::DEV_SYSCTL;
		end else begin
			next_device = pc_io_pkg::DEV_NONE;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset_cpu) begin
			io_device   <= pc_io_pkg::DEV_NONE;
			io_addr_alt <= 1'b0;
		end else begin
			io_device   <= next_device;
			io_addr_alt <= io_address[9]; // 3F6h/376h sit above the task file
		end
	end

endmodule

`default_nettype wire

// File: mgmt_page_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module mgmt_page_decoder (
	input  logic                              clk_sys,
	input  logic                              reset_cpu,
	input  logic [pc_io_pkg::MGMT_ADDR_W-1:0] mgmt_address,
	output pc_io_pkg::mgmt_target_t           mgmt_target,
	output logic [3:0]                        mgmt_offset
);

	pc_io_pkg::mgmt_target_t next_target;
	logic [7:0]              page;

	assign page = mgmt_address[pc_io_pkg::MGMT_ADDR_W-1 -: 8];

	always_comb begin
		case (page)
			pc_io_pkg::MGMT_PAGE_HDD0: next_target = pc_io_pkg::MGMT_HDD0;
			pc_io_pkg::MGMT_PAGE_HDD1: next_target = pc_io_pkg::MGMT_HDD1;
			pc_io_pkg::MGMT_PAGE_FDD0: next_target = pc_io_pkg::MGMT_FDD0;
			pc_io_pkg::MGMT_PAGE_RTC:  next_target = pc_io_pkg::MGMT_RTC;
			default:                   next_target = pc_io_pkg::MGMT_NONE;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset_cpu) begin
			mgmt_target <= pc_io_pkg::MGMT_NONE;
		end else begin
			mgmt_target <= next_target;
		end
	end

	// Register offset within the page, kept aligned with the target code
	always_ff @(posedge clk_sys) begin
		mgmt_offset <= mgmt_address[3:0];
	end

endmodule

`default_nettype wire

// File: pc_io_fabric.sv
`timescale 1ns/1ps
`default_nettype none

module pc_io_fabric (
	input  logic                              clk_sys,
	input  logic                              reset_cpu,
	input  logic [pc_io_pkg::IO_ADDR_W-1:0]   io_address,
	input  logic                              io_read,
	input  logic                              io_write,
	input  logic [pc_io_pkg::IO_SIZE_W-1:0]   io_datasize,
	input  logic [pc_io_pkg::IO_DATA_W-1:0]   io_writedata,
	input  logic [pc_io_pkg::IO_DATA_W-1:0]   hdd0_readdata,
	input  logic [pc_io_pkg::IO_DATA_W-1:0]   hdd1_readdata,
	input  logic [7:0]                        floppy_readdata,
	input  logic [7:0]                        dma_readdata,
	input  logic [7:0]                        pic_readdata,
	input  logic [7:0]                        pit_readdata,
	input  logic [7:0]                        ps2_readdata,
	input  logic [7:0]                        rtc_readdata,
	input  logic [7:0]                        sound_readdata,
	input  logic [7:0]                        uart_readdata,
	input  logic [7:0]                        vga_readdata,
	input  logic [7:0]                        joy_readdata,
	input  logic [pc_io_pkg::MGMT_ADDR_W-1:0] mgmt_address,
	input  logic                              mgmt_write,
	input  logic [pc_io_pkg::MGMT_DATA_W-1:0] fdd0_mgmt_readdata,
	input  logic [pc_io_pkg::MGMT_DATA_W-1:0] hdd0_mgmt_readdata,
	input  logic [pc_io_pkg::MGMT_DATA_W-1:0] hdd1_mgmt_readdata,
	output logic [pc_io_pkg::NUM_IO_DEV-1:0]  io_dev_read,
	output logic [pc_io_pkg::NUM_IO_DEV-1:0]  io_dev_write,
	output logic [pc_io_pkg::IO_DATA_W-1:0]   io_readdata,
	output logic                              io_io32,
	output logic [7:0]                        syscfg,
	output logic [4:0]                        mgmt_dev_write,
	output logic [3:0]                        mgmt_offset,
	output logic [pc_io_pkg::MGMT_DATA_W-1:0] mgmt_readdata
);

	pc_io_pkg::io_device_t   io_device;
	logic                    io_addr_alt;
	pc_io_pkg::mgmt_target_t mgmt_target;

	io_port_decoder u_io_port_decoder (
		.clk_sys     (clk_sys),
		.reset_cpu   (reset_cpu),
		.io_address  (io_address),
		.io_device   (io_device),
		.io_addr_alt (io_addr_alt)
	);

	mgmt_page_decoder u_mgmt_page_decoder (
		.clk_sys      (clk_sys),
		.reset_cpu    (reset_cpu),
		.mgmt_address (mgmt_address),
		.mgmt_target  (mgmt_target),
		.mgmt_offset  (mgmt_offset)
	);

	bus_return u_bus_return (
		.clk_sys            (clk_sys),
		.reset_cpu          (reset_cpu),
		.io_device          (io_device),
		.io_addr_alt        (io_addr_alt),
		.io_read            (io_read),
		.io_write           (io_write),
		.io_datasize        (io_datasize),
		.io_writedata       (io_writedata),
		.hdd0_readdata      (hdd0_readdata),
		.hdd1_readdata      (hdd1_readdata),
		.floppy_readdata    (floppy_readdata),
		.dma_readdata       (dma_readdata),
		.pic_readdata       (pic_readdata),
		.pit_readdata       (pit_readdata),
		.ps2_readdata       (ps2_readdata),
		.rtc_readdata       (rtc_readdata),
		.sound_readdata     (sound_readdata),
		.uart_readdata      (uart_readdata),
		.vga_readdata       (vga_readdata),
		.joy_readdata       (joy_readdata),
		.mgmt_target        (mgmt_target),
		.mgmt_write         (mgmt_write),
		.fdd0_mgmt_readdata (fdd0_mgmt_readdata),
		.hdd0_mgmt_readdata (hdd0_mgmt_readdata),
		.hdd1_mgmt_readdata (hdd1_mgmt_readdata),
		.io_dev_read        (io_dev_read),
		.io_dev_write       (io_dev_write),
		.io_readdata        (io_readdata),
		.io_io32            (io_io32),
		.syscfg             (syscfg),
		.mgmt_dev_write     (mgmt_dev_write),
		.mgmt_readdata      (mgmt_readdata)
	);

endmodule

`default_nettype wire

// File: pc_io_pkg.sv
`default_nettype none

package pc_io_pkg;

	localparam int IO_ADDR_W   = 16;
	localparam int IO_DATA_W   = 32;
	localparam int IO_SIZE_W   = 3;
	localparam int MGMT_ADDR_W = 16;
	localparam int MGMT_DATA_W = 32;

	// Decoded I/O device, also the bit index into the strobe vectors
	typedef enum logic [3:0] {
		DEV_NONE   = 4'd0,
		DEV_HDD0   = 4'd1,
		DEV_HDD1   = 4'd2,
		DEV_FDD0   = 4'd3,
		DEV_DMA    = 4'd4,
		DEV_PIC    = 4'd5,
		DEV_PIT    = 4'd6,
		DEV_PS2    = 4'd7,
		DEV_RTC    = 4'd8,
		DEV_SOUND  = 4'd9,
		DEV_UART   = 4'd10,
		DEV_VGA    = 4'd11,
		DEV_JOY    = 4'd12,
		DEV_SYSCTL = 4'd13
	} io_device_t;

	localparam int NUM_IO_DEV = 14;

	// Port ranges as base address plus number of ignored low address bits
	localparam logic [IO_ADDR_W-1:0] HDD0_BASE       = 16'h01F0;
	localparam int                   HDD0_IGN        = 3;
	localparam logic [IO_ADDR_W-1:0] HDD0_ALT        = 16'h03F6; // Alternate status
	localparam logic [IO_ADDR_W-1:0] HDD1_BASE       = 16'h0170;
	localparam int                   HDD1_IGN        = 3;
	localparam logic [IO_ADDR_W-1:0] HDD1_ALT        = 16'h0376;
	localparam logic [IO_ADDR_W-1:0] FDD0_BASE       = 16'h03F0;
	localparam int                   FDD0_IGN        = 3;
	localparam logic [IO_ADDR_W-1:0] DMA_MASTER_BASE = 16'h00C0;
	localparam int                   DMA_MASTER_IGN  = 5;
	localparam logic [IO_ADDR_W-1:0] DMA_PAGE_BASE   = 16'h0080;
	localparam int                   DMA_PAGE_IGN    = 4;
	localparam logic [IO_ADDR_W-1:0] DMA_SLAVE_BASE  = 16'h0000;
	localparam int                   DMA_SLAVE_IGN   = 4;
	localparam logic [IO_ADDR_W-1:0] PIC_MASTER_BASE = 16'h0020;
	localparam int                   PIC_MASTER_IGN  = 1;
	localparam logic [IO_ADDR_W-1:0] PIC_SLAVE_BASE  = 16'h00A0;
	localparam int                   PIC_SLAVE_IGN   = 1;
	localparam logic [IO_ADDR_W-1:0] PIT_BASE        = 16'h0040;
	localparam int                   PIT_IGN         = 2;
	localparam logic [IO_ADDR_W-1:0] PIT_ALT         = 16'h0061; // Speaker gate, inside the PS/2 range
	localparam logic [IO_ADDR_W-1:0] PS2_IO_BASE     = 16'h0060;
	localparam int                   PS2_IO_IGN      = 3;
	localparam logic [IO_ADDR_W-1:0] PS2_CTL_BASE    = 16'h0090;
	localparam int                   PS2_CTL_IGN     = 4;
	localparam logic [IO_ADDR_W-1:0] RTC_BASE        = 16'h0070;
	localparam int                   RTC_IGN         = 1;
	localparam logic [IO_ADDR_W-1:0] SB_BASE         = 16'h0220;
	localparam int                   SB_IGN          = 4;
	localparam logic [IO_ADDR_W-1:0] FM_BASE         = 16'h0388;
	localparam int                   FM_IGN          = 2;
	localparam logic [IO_ADDR_W-1:0] UART_BASE       = 16'h03F8;
	localparam int                   UART_IGN        = 3;
	localparam logic [IO_ADDR_W-1:0] MPU_BASE        = 16'h0330;
	localparam int                   MPU_IGN         = 1;
	localparam logic [IO_ADDR_W-1:0] VGA_B_BASE      = 16'h03B0;
	localparam logic [IO_ADDR_W-1:0] VGA_C_BASE      = 16'h03C0;
	localparam logic [IO_ADDR_W-1:0] VGA_D_BASE      = 16'h03D0;
	localparam int                   VGA_IGN         = 4;
	localparam logic [IO_ADDR_W-1:0] JOY_PORT        = 16'h0201;

	localparam logic [IO_ADDR_W-1:0] SYSCTL_PORT = 16'h8888;
	localparam logic [7:0]           SYSCTL_KEY  = 8'hA1;
	localparam logic [IO_SIZE_W-1:0] SYSCTL_SIZE = 3'd2;

	// Management bus targets, index into mgmt_dev_write
	typedef enum logic [2:0] {
		MGMT_NONE = 3'd0,
		MGMT_HDD0 = 3'd1,
		MGMT_HDD1 = 3'd2,
		MGMT_FDD0 = 3'd3,
		MGMT_RTC  = 3'd4
	} mgmt_target_t;

	localparam logic [7:0] MGMT_PAGE_HDD0 = 8'hF0;
	localparam logic [7:0] MGMT_PAGE_HDD1 = 8'hF1;
	localparam logic [7:0] MGMT_PAGE_FDD0 = 8'hF2;
	localparam logic [7:0] MGMT_PAGE_RTC  = 8'hF4;

endpackage

`default_nettype wire

// File: tb_pc_io_fabric.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pc_io_fabric;

	localparam int RESET_CYCLES  = 16;
	localparam int IDLE_TIMEOUT  = 32;
	localparam int MAX_ENTRIES   = 32;

	logic        clk_sys;
	logic        reset_cpu;
	logic [15:0] io_address;
	logic        io_read;
	logic        io_write;
	logic [2:0]  io_datasize;
	logic [31:0] io_writedata;
	logic [31:0] hdd0_readdata;
	logic [31:0] hdd1_readdata;
	logic [7:0]  floppy_readdata;
	logic [7:0]  dma_readdata;
	logic [7:0]  pic_readdata;
	logic [7:0]  pit_readdata;
	logic [7:0]  ps2_readdata;
	logic [7:0]  rtc_readdata;
	logic [7:0]  sound_readdata;
	logic [7:0]  uart_readdata;
	logic [7:0]  vga_readdata;
	logic [7:0]  joy_readdata;
	logic [15:0] mgmt_address;
	logic        mgmt_write;
	logic [31:0] fdd0_mgmt_readdata;
	logic [31:0] hdd0_mgmt_readdata;
	logic [31:0] hdd1_mgmt_readdata;
	logic [13:0] io_dev_read;
	logic [13:0] io_dev_write;
	logic [31:0] io_readdata;
	logic        io_io32;
	logic [7:0]  syscfg;
	logic [4:0]  mgmt_dev_write;
	logic [3:0]  mgmt_offset;
	logic [31:0] mgmt_readdata;

	// Reference port table in priority order
	logic [15:0] tbl_base [MAX_ENTRIES];
	int          tbl_ign  [MAX_ENTRIES];
	logic [3:0]  tbl_dev  [MAX_ENTRIES];
	int          tbl_count;
	logic [7:0]  exp_syscfg;

	pc_io_fabric u_dut (.*);

	initial clk_sys = 1'b0;
	always #50 clk_sys = ~clk_sys;

	task automatic stop_on_failure(input string what);
		$display("ERROR: %s", what);
		$display("TEST FAILED");
		$fatal(1, "%s", what);
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("FAIL %s expected %h actual %h", name, expected, actual);
			$display("TEST FAILED");
			$fatal(1, "Mismatch in %s", name);
		end
	endtask

	strobe_onehot: assert property (@(posedge clk_sys) disable iff (reset_cpu)
		$onehot0(io_dev_read) && $onehot0(io_dev_write))
		else stop_on_failure("more than one I/O strobe bit was high at once");
	none_bit_low: assert property (@(posedge clk_sys)
		!io_dev_read[0] && !io_dev_write[0] && !mgmt_dev_write[0])
		else stop_on_failure("a strobe bit for the NONE code was raised");
	io_idle: assert property (@(posedge clk_sys)
		(!io_read && !io_write) |-> (io_dev_read == '0 && io_dev_write == '0))
		else stop_on_failure("an I/O strobe was raised with no bus strobe");
	mgmt_idle: assert property (@(posedge clk_sys) !mgmt_write |-> (mgmt_dev_write == '0))
		else stop_on_failure("a management write strobe was raised with no mgmt_write");

	task automatic add_entry(input logic [15:0] base, input int ign, input logic [3:0] dev);
		tbl_base[tbl_count] = base;
		tbl_ign[tbl_count]  = ign;
		tbl_dev[tbl_count]  = dev;
		tbl_count++;
	endtask

	task automatic load_port_table();
		tbl_count = 0;
		add_entry(pc_io_pkg::HDD0_BASE, pc_io_pkg::HDD0_IGN, pc_io_pkg::DEV_HDD0);
		add_entry(pc_io_pkg::HDD0_ALT, 0, pc_io_pkg::DEV_HDD0);
		add_entry(pc_io_pkg::HDD1_BASE, pc_io_pkg::HDD1_IGN, pc_io_pkg::DEV_HDD1);
		add_entry(pc_io_pkg::HDD1_ALT, 0, pc_io_pkg::DEV_HDD1);
		add_entry(pc_io_pkg::FDD0_BASE, pc_io_pkg::FDD0_IGN, pc_io_pkg::DEV_FDD0);
		add_entry(pc_io_pkg::DMA_MASTER_BASE, pc_io_pkg::DMA_MASTER_IGN, pc_io_pkg::DEV_DMA);
		add_entry(pc_io_pkg::DMA_SLAVE_BASE, pc_io_pkg::DMA_SLAVE_IGN, pc_io_pkg::DEV_DMA);
		add_entry(pc_io_pkg::DMA_PAGE_BASE, pc_io_pkg::DMA_PAGE_IGN, pc_io_pkg::DEV_DMA);
		add_entry(pc_io_pkg::PIC_MASTER_BASE, pc_io_pkg::PIC_MASTER_IGN, pc_io_pkg::DEV_PIC);
		add_entry(pc_io_pkg::PIC_SLAVE_BASE, pc_io_pkg::PIC_SLAVE_IGN, pc_io_pkg::DEV_PIC);
		add_entry(pc_io_pkg::PIT_BASE, pc_io_pkg::PIT_IGN, pc_io_pkg::DEV_PIT);
		add_entry(pc_io_pkg::PIT_ALT, 0, pc_io_pkg::DEV_PIT); // Ahead of the PS/2 block
		add_entry(pc_io_pkg::PS2_IO_BASE, pc_io_pkg::PS2_IO_IGN, pc_io_pkg::DEV_PS2);
		add_entry(pc_io_pkg::PS2_CTL_BASE, pc_io_pkg::PS2_CTL_IGN, pc_io_pkg::DEV_PS2);
		add_entry(pc_io_pkg::RTC_BASE, pc_io_pkg::RTC_IGN, pc_io_pkg::DEV_RTC);
		add_entry(pc_io_pkg::SB_BASE, pc_io_pkg::SB_IGN, pc_io_pkg::DEV_SOUND);
		add_entry(pc_io_pkg::FM_BASE, pc_io_pkg::FM_IGN, pc_io_pkg::DEV_SOUND);
		add_entry(pc_io_pkg::UART_BASE, pc_io_pkg::UART_IGN, pc_io_pkg::DEV_UART);
		add_entry(pc_io_pkg::MPU_BASE, pc_io_pkg::MPU_IGN, pc_io_pkg::DEV_UART);
		add_entry(pc_io_pkg::VGA_B_BASE, pc_io_pkg::VGA_IGN, pc_io_pkg::DEV_VGA);
		add_entry(pc_io_pkg::VGA_C_BASE, pc_io_pkg::VGA_IGN, pc_io_pkg::DEV_VGA);
		add_entry(pc_io_pkg::VGA_D_BASE, pc_io_pkg::VGA_IGN, pc_io_pkg::DEV_VGA);
		add_entry(pc_io_pkg::JOY_PORT, 0, pc_io_pkg::DEV_JOY);
		add_entry(pc_io_pkg::SYSCTL_PORT, 0, pc_io_pkg::DEV_SYSCTL);
	endtask

	function automatic logic [3:0] expected_device(input logic [15:0] addr);
		for (int i = 0; i < tbl_count; i++) begin
			if ((addr >> tbl_ign[i]) == (tbl_base[i] >> tbl_ign[i])) begin
				return tbl_dev[i];
			end
		end
		return pc_io_pkg::DEV_NONE;
	endfunction

	function automatic logic [31:0] expected_readdata(input logic [3:0] dev);
		case (dev)
			pc_io_pkg::DEV_HDD0:  return hdd0_readdata;
			pc_io_pkg::DEV_HDD1:  return hdd1_readdata;
			pc_io_pkg::DEV_FDD0:  return {24'd0, floppy_readdata};
			pc_io_pkg::DEV_DMA:   return {24'd0, dma_readdata};
			pc_io_pkg::DEV_PIC:   return {24'd0, pic_readdata};
			pc_io_pkg::DEV_PIT:   return {24'd0, pit_readdata};
			pc_io_pkg::DEV_PS2:   return {24'd0, ps2_readdata};
			pc_io_pkg::DEV_RTC:   return {24'd0, rtc_readdata};
			pc_io_pkg::DEV_SOUND: return {24'd0, sound_readdata};
			pc_io_pkg::DEV_UART:  return {24'd0, uart_readdata};
			pc_io_pkg::DEV_VGA:   return {24'd0, vga_readdata};
			pc_io_pkg::DEV_JOY:   return {24'd0, joy_readdata};
			default:              return 32'h0000_00FF;
		endcase
	endfunction

	// Byte values are distinct from each other and from the open-bus value
	task automatic pick_peripheral_data();
		logic [7:0] val8 [10];
		logic [7:0] cand;
		logic       dup;
		for (int i = 0; i < 10; i++) begin
			do begin
				cand = 8'($urandom);
				dup  = (cand == 8'hFF);
				for (int j = 0; j < i; j++) begin
					if (val8[j] == cand) begin
						dup = 1'b1;
					end
				end
			end while (dup);
			val8[i] = cand;
		end
		floppy_readdata    = val8[0];
		dma_readdata       = val8[1];
		pic_readdata       = val8[2];
		pit_readdata       = val8[3];
		ps2_readdata       = val8[4];
		rtc_readdata       = val8[5];
		sound_readdata     = val8[6];
		uart_readdata      = val8[7];
		vga_readdata       = val8[8];
		joy_readdata       = val8[9];
		hdd0_readdata      = $urandom;
		hdd1_readdata      = $urandom;
		fdd0_mgmt_readdata = $urandom;
		hdd0_mgmt_readdata = $urandom;
		hdd1_mgmt_readdata = $urandom;
	endtask

	task automatic apply_reset();
		@(posedge clk_sys);
		reset_cpu <= 1'b1;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		reset_cpu <= 1'b0;
		exp_syscfg = 8'd0;
		@(negedge clk_sys);
		check_value("reset syscfg", 32'd0, 32'(syscfg));
		check_value("reset read strobes", 32'd0, 32'(io_dev_read));
		check_value("reset write strobes", 32'd0, 32'(io_dev_write));
		check_value("reset mgmt strobes", 32'd0, 32'(mgmt_dev_write));
	endtask

	// Address held for one edge before a one-cycle strobe
	task automatic io_access(input logic [15:0] addr, input logic is_write,
		input logic [2:0] size, input logic [31:0] wdata);
		logic [3:0]  exp_dev;
		logic [13:0] exp_vec;
		logic        exp_io32;
		string       name;
		exp_dev  = expected_device(addr);
		exp_vec  = (exp_dev == pc_io_pkg::DEV_NONE) ? 14'd0 : (14'd1 << exp_dev);
		exp_io32 = ((exp_dev == pc_io_pkg::DEV_HDD0 || exp_dev == pc_io_pkg::DEV_HDD1) &&
			!addr[9]) || (exp_dev == pc_io_pkg::DEV_SYSCTL);
		name = $sformatf("%s %h", is_write ? "write" : "read", addr);
		@(posedge clk_sys);
		io_address <= addr;
		@(posedge clk_sys);
		io_read      <= !is_write;
		io_write     <= is_write;
		io_datasize  <= size;
		io_writedata <= wdata;
		@(negedge clk_sys);
		check_value({name, " read strobes"}, is_write ? 32'd0 : 32'(exp_vec), 32'(io_dev_read));
		check_value({name, " write strobes"}, is_write ? 32'(exp_vec) : 32'd0,
			32'(io_dev_write));
		check_value({name, " io32"}, 32'(exp_io32), 32'(io_io32));
		if (!is_write) begin
			check_value({name, " readdata"}, expected_readdata(exp_dev), io_readdata);
		end
		if (is_write && addr == 16'h8888 && size == 3'd2 && wdata[15:8] == 8'hA1) begin
			exp_syscfg = wdata[7:0];
		end
		@(posedge clk_sys);
		io_read  <= 1'b0;
		io_write <= 1'b0;
		@(negedge clk_sys);
		check_value({name, " syscfg"}, 32'(exp_syscfg), 32'(syscfg));
	endtask

	task automatic mgmt_access(input logic [7:0] page);
		logic [15:0] addr;
		logic [4:0]  exp_wr;
		logic [31:0] exp_rd;
		addr = {page, 8'($urandom)};
		case (page)
			8'hF0:   exp_wr = 5'b00010;
			8'hF1:   exp_wr = 5'b00100;
			8'hF2:   exp_wr = 5'b01000;
			8'hF4:   exp_wr = 5'b10000;
			default: exp_wr = 5'b00000;
		endcase
		case (page)
			8'hF0:   exp_rd = hdd0_mgmt_readdata;
			8'hF1:   exp_rd = hdd1_mgmt_readdata;
			default: exp_rd = fdd0_mgmt_readdata;
		endcase
		@(posedge clk_sys);
		mgmt_address <= addr;
		@(posedge clk_sys);
		mgmt_write <= 1'b1;
		@(negedge clk_sys);
		check_value($sformatf("mgmt %h strobes", addr), 32'(exp_wr), 32'(mgmt_dev_write));
		check_value($sformatf("mgmt %h readdata", addr), exp_rd, mgmt_readdata);
		check_value($sformatf("mgmt %h offset", addr), 32'(addr[3:0]), 32'(mgmt_offset));
		@(posedge clk_sys);
		mgmt_write <= 1'b0;
	endtask

	task automatic wait_bus_idle();
		int cycles;
		cycles = 0;
		while ((io_dev_read != '0 || io_dev_write != '0 || mgmt_dev_write != '0) &&
			cycles < IDLE_TIMEOUT) begin
			@(negedge clk_sys);
			cycles++;
		end
		if (io_dev_read != '0 || io_dev_write != '0 || mgmt_dev_write != '0) begin
			stop_on_failure("bus strobes did not return to idle");
		end
	endtask

	initial begin
		logic [15:0] addr;
		logic [15:0] mask;
		reset_cpu    <= 1'b1;
		io_address   <= 16'd0;
		io_read      <= 1'b0;
		io_write     <= 1'b0;
		io_datasize  <= 3'd0;
		io_writedata <= 32'd0;
		mgmt_address <= 16'd0;
		mgmt_write   <= 1'b0;
		exp_syscfg   = 8'd0;
		void'($urandom(26329));
		pick_peripheral_data();
		load_port_table();
		apply_reset();

		for (int i = 0; i < tbl_count; i++) begin
			for (int k = 0; k < 4; k++) begin
				mask = 16'((32'd1 << tbl_ign[i]) - 32'd1);
				addr = tbl_base[i] | (16'($urandom) & mask);
				io_access(addr, k[0], 3'($urandom), $urandom);
			end
		end
		io_access(16'h0200, 1'b0, 3'd1, 32'd0); // Next to the joystick port
		io_access(16'h0400, 1'b1, 3'd1, 32'd0);
		io_access(16'h8889, 1'b0, 3'd2, 32'd0);
		io_access(16'hFFFF, 1'b1, 3'd2, 32'd0);
		for (int i = 0; i < 16; i++) begin
			io_access(16'($urandom), i[0], 3'($urandom), $urandom);
		end

		io_access(16'h8888, 1'b1, 3'd2, 32'h0000_A15A);
		io_access(16'h8888, 1'b1, 3'd2, 32'h0000_A033); // Wrong key
		io_access(16'h8888, 1'b1, 3'd4, 32'h0000_A177); // Wrong size
		io_access(16'h8888, 1'b1, 3'd1, 32'h0000_A1C3);
		io_access(16'h8888, 1'b0, 3'd2, 32'd0);
		io_access(16'h8888, 1'b1, 3'd2, 32'hFFFF_A1E7);
		apply_reset();

		mgmt_access(8'hF0);
		mgmt_access(8'hF1);
		mgmt_access(8'hF2);
		mgmt_access(8'hF3);
		mgmt_access(8'hF4);
		mgmt_access(8'($urandom % 32'd240)); // Below the mapped pages
		wait_bus_idle();

		$display("TEST OK");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
pc_io_pkg.sv
io_port_decoder.sv
mgmt_page_decoder.sv
bus_return.sv
pc_io_fabric.sv
tb_pc_io_fabric.sv
